// File: cdb_complete.f
src/complete_pkg.sv
src/fu_result_latch.sv
src/complete_select.sv
src/phys_reg_file.sv
src/rob_complete_tracker.sv
src/complete_top.sv
tb/complete_tb.sv

// File: Makefile
FLIST := cdb_complete.f
LOG   := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f $(FLIST) --top-module complete_tb

sim:
	verilator --binary --timing -f $(FLIST) --top-module complete_tb -Mdir obj_dir
	./obj_dir/Vcomplete_tb | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb/complete_tb.sv
`timescale 1ns/1ps

module complete_tb import complete_pkg::*;;

    logic                 clock;
    logic                 rst;
    logic         [7:0]   fu_done;
    fu_complete_t [7:0]   fu_result;
    logic         [7:0]   fu_ready;
    logic                 dispatch_valid;
    rob_idx_t             dispatch_entry;
    pr_idx_t              rd_addr_a;
    pr_idx_t              rd_addr_b;
    xlen_t                rd_data_a;
    xlen_t                rd_data_b;
    rob_idx_t             query_entry;
    logic                 rob_complete;
    logic                 redirect_valid;
    xlen_t                redirect_pc;
    rob_idx_t             redirect_entry;

    integer seed = 32'h33ec30f3;

    // cycle model of the slots, the register array, the complete bits and the redirect
    logic         [7:0]  m_full;
    fu_complete_t        m_res [8];
    xlen_t               m_regs [64];
    logic         [31:0] m_complete;
    logic                m_redir_valid;
    xlen_t               m_redir_pc;
    rob_idx_t            m_redir_entry;
    pr_idx_t             m_last_dest;

    // inputs that the DUT samples at the coming edge
    logic         [7:0]  cur_done;
    fu_complete_t        cur_res [8];
    logic                cur_disp_v;
    rob_idx_t            cur_disp_e;

    complete_top #(.NUM_FU(8), .NUM_PR(64), .ROB_DEPTH(32)) DUT (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input xlen_t exp, input xlen_t act);
        if (exp !== act) begin
            report_fail($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            report_fail($sformatf("[ERROR] %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_entry(input string name, input rob_idx_t exp, input rob_idx_t act);
        if (exp !== act) begin
            report_fail($sformatf("[ERROR] %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_ready(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act) begin
            report_fail($sformatf("[ERROR] %s expected %b actual %b", name, exp, act));
        end
    endtask

    // the three lowest full slots win the bus, in unit order
    function automatic logic [7:0] grant_of(input logic [7:0] full);
        logic [7:0] g;
        int cnt;
        g = '0;
        cnt = 0;
        for (int i = 0; i < 8; i++) begin
            if (full[i] && cnt < 3) begin
                g[i] = 1'b1;
                cnt++;
            end
        end
        return g;
    endfunction

    function automatic int urand(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // advance the model by one edge with the inputs the DUT saw
    task automatic update_model();
        logic [7:0] g;
        logic br_seen;
        g = grant_of(m_full);
        br_seen = 1'b0;
        m_redir_valid = 1'b0;
        // dispatch clears first so that a completion to the same entry wins
        if (cur_disp_v) begin
            m_complete[cur_disp_e] = 1'b0;
        end
        for (int i = 0; i < 8; i++) begin
            if (g[i]) begin
                if (m_res[i].dest_pr != 0) begin
                    m_regs[m_res[i].dest_pr] = m_res[i].dest_value;
                end
                // port b reads back the last destination, register 0 included
                m_last_dest = m_res[i].dest_pr;
                m_complete[m_res[i].rob_entry] = 1'b1;
                // ascending unit order is ascending lane order
                if (m_res[i].take_branch && !br_seen) begin
                    br_seen = 1'b1;
                    m_redir_valid = 1'b1;
                    m_redir_pc = m_res[i].target_pc;
                    m_redir_entry = m_res[i].rob_entry;
                end
            end
        end
        m_full = (m_full & ~g) | cur_done;
        for (int i = 0; i < 8; i++) begin
            if (cur_done[i]) begin
                m_res[i] = cur_res[i];
            end
        end
    endtask

    // one clock cycle: model step, new stimulus at the edge, checks mid cycle
    // a negative entry or query means a random one
    task automatic cycle(input string name, input logic [7:0] want, input logic dv,
                         input int de, input int q, input int br_pct, input int entry);
        fu_complete_t r;
        logic [7:0] ready;
        pr_idx_t ra;
        rob_idx_t qe;
        @(posedge clock);
        update_model();
        ready = ~m_full | grant_of(m_full);
        cur_done = want & ready;
        for (int i = 0; i < 8; i++) begin
            // low bits from the unit index keep lane destinations distinct
            r.dest_pr = {3'(urand(8)), i[2:0]};
            r.dest_value = $random(seed);
            r.rob_entry = (entry < 0) ? rob_idx_t'(urand(32)) : rob_idx_t'(entry);
            r.take_branch = urand(100) < br_pct;
            r.target_pc = $random(seed) & 32'hffff_fffc;
            cur_res[i] = r;
            fu_result[i] <= r;
        end
        cur_disp_v = dv;
        cur_disp_e = (de < 0) ? rob_idx_t'(urand(32)) : rob_idx_t'(de);
        ra = pr_idx_t'(urand(64));
        qe = (q < 0) ? rob_idx_t'(urand(32)) : rob_idx_t'(q);
        fu_done <= cur_done;
        dispatch_valid <= cur_disp_v;
        dispatch_entry <= cur_disp_e;
        rd_addr_a <= ra;
        rd_addr_b <= m_last_dest;
        query_entry <= qe;
        @(negedge clock);
        check_ready({name, " fu_ready"}, ready, fu_ready);
        check_data({name, " rd_data_a"}, (ra == 0) ? '0 : m_regs[ra], rd_data_a);
        check_data({name, " rd_data_b"}, (m_last_dest == 0) ? '0 : m_regs[m_last_dest],
                   rd_data_b);
        check_bit({name, " rob_complete"}, m_complete[qe], rob_complete);
        check_bit({name, " redirect_valid"}, m_redir_valid, redirect_valid);
        if (m_redir_valid) begin
            check_data({name, " redirect_pc"}, m_redir_pc, redirect_pc);
            check_entry({name, " redirect_entry"}, m_redir_entry, redirect_entry);
        end
    endtask

    // run idle cycles until every slot is empty and no capture is pending, with a bound
    task automatic drain(input string name);
        int guard;
        guard = 0;
        while (m_full != 0 || cur_done != 0) begin
            cycle(name, 8'h00, 1'b0, 0, -1, 0, -1);
            guard++;
            if (guard > 40) begin
                report_fail({name, ": held results did not drain from the slots in time"});
            end
        end
    endtask

    initial begin
        rst = 1'b1;
        fu_done = '0;
        fu_result = '0;
        dispatch_valid = 1'b0;
        dispatch_entry = '0;
        rd_addr_a = '0;
        rd_addr_b = '0;
        query_entry = '0;
        m_full = '0;
        m_complete = '0;
        m_redir_valid = 1'b0;
        m_redir_pc = '0;
        m_redir_entry = '0;
        m_last_dest = '0;
        cur_done = '0;
        cur_disp_v = 1'b0;
        cur_disp_e = '0;
        for (int i = 0; i < 8; i++) begin
            m_res[i] = '0;
            cur_res[i] = '0;
        end
        for (int r = 0; r < 64; r++) begin
            m_regs[r] = '0;
        end
        repeat (8) @(posedge clock);
        rst <= 1'b0;

        // every complete bit is queried once while the core is idle
        for (int e = 0; e < 32; e++) begin
            cycle("reset", 8'h00, 1'b0, 0, e, 0, -1);
        end

        // one or two units at a time on a freshly dispatched entry, which reads
        // incomplete one edge after the capture and complete at the next one
        for (int n = 0; n < 60; n++) begin
            cycle("light", (8'h1 << urand(8)) | ((n % 2) ? (8'h1 << urand(8)) : 8'h0),
                  1'b1, n % 32, n % 32, 0, n % 32);
            cycle("light", 8'h00, 1'b0, 0, n % 32, 0, -1);
            cycle("light", 8'h00, 1'b0, 0, n % 32, 0, -1);
            drain("light");
        end

        // all eight units together, twice, without and with taken branches
        cycle("contention", 8'hff, 1'b0, 0, -1, 0, -1);
        drain("contention");
        for (int n = 0; n < 20; n++) begin
            cycle("redirect", 8'hff, 1'b0, 0, -1, 40, -1);
            drain("redirect");
        end

        // dispatch clears an entry, a completion sets it again, a clash keeps it set
        cycle("alloc", 8'h00, 1'b1, 7, 7, 0, -1);
        cycle("alloc", 8'h04, 1'b0, 0, 7, 0, 7);
        cycle("alloc", 8'h00, 1'b1, 7, 7, 0, -1);
        cycle("alloc", 8'h00, 1'b0, 0, 7, 0, -1);
        cycle("alloc", 8'h00, 1'b0, 0, 7, 0, -1);
        drain("alloc");

        for (int n = 0; n < 4000; n++) begin
            cycle("random", 8'(urand(256)), 1'(urand(2)), -1, -1, 20, -1);
        end
        drain("random");

        $display("Regression passed");
        $finish;
    end

endmodule

// File: src/complete_top.sv
`timescale 1ns/1ps

module complete_top import complete_pkg::*; #(
    parameter int NUM_FU    = 8,
    parameter int NUM_PR    = 64,
    parameter int ROB_DEPTH = 32
) (
    input  logic                      clock,
    input  logic                      rst,
    // functional unit side
    input  logic         [NUM_FU-1:0] fu_done,
    input  fu_complete_t [NUM_FU-1:0] fu_result,
    output logic         [NUM_FU-1:0] fu_ready,
    // entry allocation from dispatch
    input  logic                      dispatch_valid,
    input  rob_idx_t                  dispatch_entry,
    // register file read ports
    input  pr_idx_t                   rd_addr_a,
    input  pr_idx_t                   rd_addr_b,
    output xlen_t                     rd_data_a,
    output xlen_t                     rd_data_b,
    // completion status and redirect
    input  rob_idx_t                  query_entry,
    output logic                      rob_complete,
    output logic                      redirect_valid,
    output xlen_t                     redirect_pc,
    output rob_idx_t                  redirect_entry
);

    logic         [NUM_FU-1:0]    slot_full;
    fu_complete_t [NUM_FU-1:0]    slot_res;
    logic         [NUM_FU-1:0]    grant;
    cdb_lane_t    [CDB_WIDTH-1:0] cdb;

    fu_result_latch #(
        .NUM_FU(NUM_FU)
    ) u_latch (
        .clock(clock),
        .rst(rst),
        .fu_done(fu_done),
        .fu_result(fu_result),
        .grant(grant),
        .fu_ready(fu_ready),
        .slot_full(slot_full),
        .slot_res(slot_res)
    );

    // the latch builds fu_ready from grant and its own full bits, which
    // equals the inverted stall vector, so stall is not routed further
    complete_select #(
        .NUM_FU(NUM_FU)
    ) u_select (
        .slot_full(slot_full),
        .slot_res(slot_res),
        .grant(grant),
        .stall(),
        .cdb(cdb)
    );

    phys_reg_file #(
        .NUM_PR(NUM_PR)
    ) u_prf (
        .clock(clock),
        .rst(rst),
        .cdb(cdb),
        .rd_addr_a(rd_addr_a),
        .rd_addr_b(rd_addr_b),
        .rd_data_a(rd_data_a),
        .rd_data_b(rd_data_b)
    );

    rob_complete_tracker #(
        .ROB_DEPTH(ROB_DEPTH)
    ) u_tracker (
        .clock(clock),
        .rst(rst),
        .cdb(cdb),
        .dispatch_valid(dispatch_valid),
        .dispatch_entry(dispatch_entry),
        .query_entry(query_entry),
        .rob_complete(rob_complete),
        .redirect_valid(redirect_valid),
        .redirect_pc(redirect_pc),
        .redirect_entry(redirect_entry)
    );

endmodule

// File: src/rob_complete_tracker.sv
`timescale 1ns/1ps

module rob_complete_tracker import complete_pkg::*; #(
    parameter int ROB_DEPTH = 32
) (
    input  logic                      clock,
    input  logic                      rst,
    input  cdb_lane_t [CDB_WIDTH-1:0] cdb,
    // a newly allocated entry starts out incomplete
    input  logic                      dispatch_valid,
    input  rob_idx_t                  dispatch_entry,
    input  rob_idx_t                  query_entry,
    output logic                      rob_complete,
    // one cycle redirect request for a taken branch
    output logic                      redirect_valid,
    output xlen_t                     redirect_pc,
    output rob_idx_t                  redirect_entry
);

    // one complete bit per reorder buffer entry
    logic [ROB_DEPTH-1:0] complete_bits;

    logic [ROB_DEPTH-1:0] set_mask;
    logic [ROB_DEPTH-1:0] clr_mask;

    // taken branch seen on the bus this cycle, and the lowest lane with it
    logic     br_hit;
    xlen_t    br_pc;
    rob_idx_t br_entry;

    // entries completed by the bus this cycle
    always_comb begin
        set_mask = '0;
        for (int k = 0; k < CDB_WIDTH; k++) begin
            if (cdb[k].valid) begin
                set_mask[cdb[k].res.rob_entry] = 1'b1;
            end
        end
    end

    // entry cleared by a dispatch this cycle
    always_comb begin
        clr_mask = '0;
        if (dispatch_valid) begin
            clr_mask[dispatch_entry] = 1'b1;
        end
    end

    // the set is applied after the clear, so a completion to the entry
    // being dispatched in the same cycle leaves the bit set
    always_ff @(posedge clock) begin
        if (rst) begin
            complete_bits <= '0;
        end else begin
            complete_bits <= (complete_bits & ~clr_mask) | set_mask;
        end
    end

    assign rob_complete = complete_bits[query_entry];

    // walk the lanes from the top down so the lowest taken lane is the
    // one left standing at the end of the loop
    always_comb begin
        br_hit = 1'b0;
        br_pc = '0;
        br_entry = '0;
        for (int k = CDB_WIDTH - 1; k >= 0; k--) begin
            if (cdb[k].valid && cdb[k].res.take_branch) begin
                br_hit = 1'b1;
                br_pc = cdb[k].res.target_pc;
                br_entry = cdb[k].res.rob_entry;
            end
        end
    end

    // the redirect is a pulse, it drops again unless another taken
    // branch completes in the following cycle
    always_ff @(posedge clock) begin
        if (rst) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= br_hit;
        end
    end

    // target and entry are only looked at while redirect_valid is high
    always_ff @(posedge clock) begin
        if (br_hit) begin
            redirect_pc <= br_pc;
            redirect_entry <= br_entry;
        end
    end

endmodule

// File: src/phys_reg_file.sv
`timescale 1ns/1ps

module phys_reg_file import complete_pkg::*; #(
    parameter int NUM_PR = 64
) (
    input  logic                      clock,
    input  logic                      rst,
    // writeback lanes, each may write one register per cycle
    input  cdb_lane_t [CDB_WIDTH-1:0] cdb,
    input  pr_idx_t                   rd_addr_a,
    input  pr_idx_t                   rd_addr_b,
    output xlen_t                     rd_data_a,
    output xlen_t                     rd_data_b
);

    xlen_t regs [NUM_PR];

    // per lane write enable, lanes aimed at register 0 write nothing
    logic [CDB_WIDTH-1:0] wr_en;

    always_comb begin
        for (int k = 0; k < CDB_WIDTH; k++) begin
            wr_en[k] = cdb[k].valid && (cdb[k].res.dest_pr != '0);
        end
    end

    // the whole array starts at zero, which the rest of the core relies
    // on for registers that were never produced
    // destinations on the three lanes are distinct, so the lane order in
    // this loop never decides between two writes
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int r = 0; r < NUM_PR; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int k = 0; k < CDB_WIDTH; k++) begin
                if (wr_en[k]) begin
                    regs[cdb[k].res.dest_pr] <= cdb[k].res.dest_value;
                end
            end
        end
    end

    // asynchronous reads with no bypass, a value written at an edge
    // shows up on the read port only after that edge
    // register 0 is forced to zero on the read side as well
    always_comb begin
        rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
        rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];
    end

endmodule

// File: src/complete_select.sv
`timescale 1ns/1ps

module complete_select import complete_pkg::*; #(
    parameter int NUM_FU = 8
) (
    // held results from the latch
    input  logic         [NUM_FU-1:0]    slot_full,
    input  fu_complete_t [NUM_FU-1:0]    slot_res,
    // slots that go out on the bus this cycle
    output logic         [NUM_FU-1:0]    grant,
    // full slots that have to wait for a later cycle
    output logic         [NUM_FU-1:0]    stall,
    output cdb_lane_t    [CDB_WIDTH-1:0] cdb
);

    // one hot pick for each bus lane, all zero when no slot is left
    logic [CDB_WIDTH-1:0][NUM_FU-1:0] pick;

    // slots still competing before each pick, the last entry is what
    // remains after all lanes are filled
    logic [CDB_WIDTH:0][NUM_FU-1:0] avail;

    // chained priority picks
    // each stage isolates the lowest set bit of what is still available
    // and masks it out before the next stage looks
    always_comb begin
        avail[0] = slot_full;
        for (int k = 0; k < CDB_WIDTH; k++) begin
            // x & -x keeps only the lowest set bit of x
            pick[k] = avail[k] & (~avail[k] + NUM_FU'(1));
            avail[k+1] = avail[k] & ~pick[k];
        end
    end

    // every pick is a grant, picks are disjoint by construction
    always_comb begin
        grant = '0;
        for (int k = 0; k < CDB_WIDTH; k++) begin
            grant = grant | pick[k];
        end
    end

    // whatever survives all three picks stalls
    assign stall = avail[CDB_WIDTH];

    // steer the picked slot of each rank onto the lane of that rank
    // lane 0 carries the lowest unit index, lane 2 the highest granted one
    // lanes without a pick stay all zero, which also keeps dest_pr at 0
    always_comb begin
        for (int k = 0; k < CDB_WIDTH; k++) begin
            cdb[k] = '0;
            for (int i = 0; i < NUM_FU; i++) begin
                if (pick[k][i]) begin
                    cdb[k].res = slot_res[i];
                end
            end
            cdb[k].valid = |pick[k];
        end
    end

endmodule

// File: src/fu_result_latch.sv
`timescale 1ns/1ps

module fu_result_latch import complete_pkg::*; #(
    parameter int NUM_FU = 8
) (
    input  logic                      clock,
    input  logic                      rst,
    // single cycle done pulses from the functional units
    input  logic         [NUM_FU-1:0] fu_done,
    input  fu_complete_t [NUM_FU-1:0] fu_result,
    // slots picked by the selector in this cycle
    input  logic         [NUM_FU-1:0] grant,
    output logic         [NUM_FU-1:0] fu_ready,
    output logic         [NUM_FU-1:0] slot_full,
    output fu_complete_t [NUM_FU-1:0] slot_res
);

    // a done pulse is only taken while the slot can accept it
    logic [NUM_FU-1:0] accept;

    // a slot leaves at the next edge when the selector grants it
    logic [NUM_FU-1:0] release_slot;

    logic [NUM_FU-1:0] full_next;

    // a unit may finish when its slot is empty, or when the held result
    // goes out on the bus this cycle and frees the slot at the same edge
    assign fu_ready = ~slot_full | grant;

    // done pulses that arrive while not ready are ignored by the units
    // by contract, masking them here keeps a held result from being overwritten
    assign accept = fu_done & fu_ready;

    // grant is only ever raised for full slots, the mask keeps that explicit
    assign release_slot = grant & slot_full;

    // a new capture wins over a release in the same cycle, so a slot that
    // is granted and refilled at once stays full with the new result
    assign full_next = accept | (slot_full & ~release_slot);

    // full bits are control state and come up empty after reset
    always_ff @(posedge clock) begin
        if (rst) begin
            slot_full <= '0;
        end else begin
            slot_full <= full_next;
        end
    end

    // the result payload only matters while the full bit is set
    always_ff @(posedge clock) begin
        for (int i = 0; i < NUM_FU; i++) begin
            if (accept[i]) begin
                slot_res[i] <= fu_result[i];
            end
        end
    end

endmodule

// File: src/complete_pkg.sv
package complete_pkg;

    // architectural data width, also used for program counters
    localparam int XLEN = 32;

    // 64 physical registers need a 6 bit index
    localparam int PR_W = 6;

    // 32 reorder buffer entries need a 5 bit index
    localparam int ROB_W = 5;

    // number of common data bus lanes driven per cycle
    localparam int CDB_WIDTH = 3;

    // a data word or a program counter
    typedef logic [XLEN-1:0] xlen_t;

    // physical register number, register 0 stands for no writeback
    typedef logic [PR_W-1:0] pr_idx_t;

    // reorder buffer entry number
    typedef logic [ROB_W-1:0] rob_idx_t;

    // one finished result as handed over by a functional unit
    typedef struct packed {
        // destination register, zero when nothing is written back
        pr_idx_t  dest_pr;
        xlen_t    dest_value;
        // reorder buffer entry that this result completes
        rob_idx_t rob_entry;
        // set for a branch that resolved as taken
        logic     take_branch;
        xlen_t    target_pc;
    } fu_complete_t;

    // one lane of the common data bus
    typedef struct packed {
        logic         valid;
        fu_complete_t res;
    } cdb_lane_t;

endpackage
